//--- source/perfCounter_defs.svh
// ==========================================================
// Sizes shared by the counter unit, its packages and bench
// The widths must hold PERF_MAX_VALUE and PERF_MAX_INCR
// A counter count above 4 needs a wider status word
// ==========================================================

`ifndef PERF_COUNTER_DEFS_SVH
`define PERF_COUNTER_DEFS_SVH

// Number of counters in the unit
`define PERF_NUM_COUNTERS 4
// Event lanes feeding each counter
`define PERF_NUM_LANES 3

// Largest count before wrap or saturation
`define PERF_MAX_VALUE 1000
`define PERF_VALUE_WIDTH 10

// Largest increment per cycle, one per raised lane
`define PERF_MAX_INCR 3
`define PERF_INCR_WIDTH 2

// Register data word
`define PERF_REG_WIDTH 16
// Counters 2 and 3 saturate, counters 0 and 1 wrap
`define PERF_SATURATE_MASK 4'b1100

`endif

//--- source/perfEventPkg.sv
// ==========================================================
// Types for event lanes, increments and counter values
// Sizes come from the shared defines header
// ==========================================================

package perfEventPkg;

  `include "perfCounter_defs.svh"

  // Raised lanes of one counter in one cycle
  // Bit i is lane 3k+i of the top level events bus
  typedef logic [`PERF_NUM_LANES-1:0] laneVec;

  // Per cycle increment
  // Zero means no event for the counter
  typedef logic [`PERF_INCR_WIDTH-1:0] incrT;

  // Counter value
  // Never above PERF_MAX_VALUE in normal operation
  typedef logic [`PERF_VALUE_WIDTH-1:0] countT;

endpackage

//--- source/perfRegPkg.sv
// ==========================================================
// Register map of the counter unit
// One 16 bit word read either as a count or as status
// Reserved and spare bits read as zero
// ==========================================================

package perfRegPkg;

  `include "perfCounter_defs.svh"

  import perfEventPkg::*;

  // Register addresses
  // COUNTk reads or presets counter k
  typedef enum logic [2:0] {
    COUNT0 = 3'd0,
    COUNT1 = 3'd1,
    COUNT2 = 3'd2,
    COUNT3 = 3'd3,
    STATUS = 3'd4
  } regAddrT;

  // Register word with two decodings
  typedef union packed {
    // Count register layout
    struct packed {
      logic [`PERF_REG_WIDTH-`PERF_VALUE_WIDTH-1:0] reserved;
      countT                                       count;
    } countView;
    // Status register layout
    struct packed {
      logic [3:0]                    reserved;
      // Saturating counters sitting at the maximum
      logic [`PERF_NUM_COUNTERS-1:0] saturatedNow;
      logic [3:0]                    spare;
      // Sticky overflow flags, write one to clear
      logic [`PERF_NUM_COUNTERS-1:0] sticky;
    } statusView;
  } regWordT;

endpackage

//--- source/eventLaneCount.sv
// ==========================================================
// Registers the event lanes and counts raised lanes
// One cycle of latency from events to incr
// Events cannot be stalled
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module eventLaneCount
  import perfEventPkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [`PERF_NUM_COUNTERS*`PERF_NUM_LANES-1:0] events,
  output incrT                                         incr [`PERF_NUM_COUNTERS],
  output logic [`PERF_NUM_COUNTERS-1:0]                incrValid
);

  // Lanes captured at the previous edge
  logic [`PERF_NUM_COUNTERS*`PERF_NUM_LANES-1:0] eventsQ;

  // Population count of one counter's lanes
  function automatic incrT countLanes(input laneVec lanes);
    incrT total;
    total = '0;
    for (int i = 0; i < `PERF_NUM_LANES; i++) begin
      total = total + incrT'(lanes[i]);
    end
    return total;
  endfunction

  // Cleared so no increment appears right after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      eventsQ <= '0;
    end else begin
      eventsQ <= events;
    end
  end

  for (genvar k = 0; k < `PERF_NUM_COUNTERS; k++) begin : genLane
    // Lanes 3k to 3k+2 belong to counter k
    assign incr[k] = countLanes(eventsQ[k*`PERF_NUM_LANES +: `PERF_NUM_LANES]);
    assign incrValid[k] = (incr[k] != '0);

    // Increment follows the lanes sampled one edge earlier
    incrMatchA: assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |->
        incr[k] == $countones($past(events[k*`PERF_NUM_LANES +: `PERF_NUM_LANES])))
      else $error("increment of counter %0d does not match its lanes", k);
  end

endmodule

//--- source/counterIncrMonitor.sv
// ==========================================================
// Reference model and checks for one counter
// Must see the same parameter as the counter it watches
// Assertions are disabled while rst is high
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module counterIncrMonitor
  import perfEventPkg::*;
#(
  parameter bit enableSaturate = 1'b0
) (
  input logic  clk,
  input logic  rst,
  input logic  reinit,
  input countT initialValue,
  input logic  incrValid,
  input incrT  incr,
  input countT value,
  input countT valueNext
);

  countT modelCount;
  incrT  modelStep;

  // Overflow rule in plain integer arithmetic
  function automatic countT applyRule(input countT base, input incrT step);
    int unsigned total;
    total = base + step;
    if (total <= `PERF_MAX_VALUE) begin
      return countT'(total);
    end
    if (enableSaturate) begin
      return countT'(`PERF_MAX_VALUE);
    end
    return countT'(total - `PERF_MAX_VALUE - 1);
  endfunction

  assign modelStep = incrValid ? incr : '0;

  // Model tracks the counter from reset onwards
  always_ff @(posedge clk) begin
    if (rst) begin
      modelCount <= '0;
    end else if (reinit) begin
      modelCount <= applyRule(initialValue, modelStep);
    end else begin
      modelCount <= applyRule(modelCount, modelStep);
    end
  end

  // Counter agrees with the model every cycle
  valueMatchA: assert property (@(posedge clk) disable iff (rst)
    value == modelCount)
    else $error("counter value %0d differs from model %0d", value, modelCount);

  valueRangeA: assert property (@(posedge clk) disable iff (rst)
    value <= `PERF_MAX_VALUE)
    else $error("counter value %0d above maximum", value);

  // Idle cycle keeps the value
  holdA: assert property (@(posedge clk) disable iff (rst)
    !(incrValid || reinit) |-> valueNext == value)
    else $error("valueNext moved without increment or preset");

  // Next value offered with an increment follows the overflow rule
  nextA: assert property (@(posedge clk) disable iff (rst)
    incrValid |=> $past(valueNext) == modelCount)
    else $error("valueNext after increment differs from model");

  // Legal inputs from the lane counter and the register port
  initLegalA: assert property (@(posedge clk) disable iff (rst)
    reinit |-> initialValue <= `PERF_MAX_VALUE)
    else $error("preset value %0d above maximum", initialValue);

  incrLegalA: assert property (@(posedge clk) disable iff (rst)
    incrValid |-> (incr <= `PERF_MAX_INCR) && (incr != '0))
    else $error("illegal increment %0d", incr);

  // Preset in the same cycle as an event
  reinitAndIncrC: cover property (@(posedge clk) disable iff (rst)
    reinit && incrValid);

endmodule

//--- source/counterIncr.sv
// ==========================================================
// One incrementing counter with preset and overflow rule
// enableSaturate selects saturation instead of wrap
// Preset and increment in one cycle apply both
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module counterIncr
  import perfEventPkg::*;
#(
  parameter bit enableSaturate = 1'b0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  reinit,
  input  countT initialValue,
  input  logic  incrValid,
  input  incrT  incr,
  output countT value,
  output countT valueNext,
  output logic  overflow
);

  // Maximum with one guard bit for the sum
  localparam logic [`PERF_VALUE_WIDTH:0] maxWide = `PERF_MAX_VALUE;

  countT                      base;
  incrT                       step;
  logic [`PERF_VALUE_WIDTH:0] sum;
  logic [`PERF_VALUE_WIDTH:0] wrapped;
  logic                       hit;

  always_comb begin
    // Preset replaces the current value as the base
    base = reinit ? initialValue : value;
    step = incrValid ? incr : '0;
    sum = {1'b0, base} + {{(`PERF_VALUE_WIDTH+1-`PERF_INCR_WIDTH){1'b0}}, step};
    hit = (sum > maxWide);
    // Wrap goes past the maximum back through zero
    wrapped = sum - maxWide - 1'b1;
    if (!hit) begin
      valueNext = sum[`PERF_VALUE_WIDTH-1:0];
    end else if (enableSaturate) begin
      valueNext = maxWide[`PERF_VALUE_WIDTH-1:0];
    end else begin
      valueNext = wrapped[`PERF_VALUE_WIDTH-1:0];
    end
  end

  // Count register plus a one cycle overflow pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      value    <= '0;
      overflow <= 1'b0;
    end else begin
      value    <= valueNext;
      overflow <= hit;
    end
  end

  // Reference model with checks on this counter
  counterIncrMonitor #(
    .enableSaturate(enableSaturate)
  ) uMonitor (
    .clk         (clk),
    .rst         (rst),
    .reinit      (reinit),
    .initialValue(initialValue),
    .incrValid   (incrValid),
    .incr        (incr),
    .value       (value),
    .valueNext   (valueNext)
  );

endmodule

//--- source/perfRegAccess.sv
// ==========================================================
// Four phase req/ack register slave for the counters
// Master holds addr, write and wdata until ack
// rdata is valid only while ack is high
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module perfRegAccess
  import perfEventPkg::*;
  import perfRegPkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic                          write,
  input  regAddrT                       addr,
  input  regWordT                       wdata,
  output logic                          ack,
  output regWordT                       rdata,
  input  countT                         value [`PERF_NUM_COUNTERS],
  input  logic [`PERF_NUM_COUNTERS-1:0] overflow,
  output logic [`PERF_NUM_COUNTERS-1:0] reinit,
  output countT                         initialValue
);

  localparam logic [`PERF_NUM_COUNTERS-1:0] saturateMask = `PERF_SATURATE_MASK;

  logic                          start;
  logic                          presetAccess;
  logic                          clearAccess;
  logic [`PERF_NUM_COUNTERS-1:0] sticky;
  logic [`PERF_NUM_COUNTERS-1:0] saturatedNow;
  regWordT                       readWord;

  // New request seen with ack still low
  assign start        = req && !ack;
  assign presetAccess = start && write && (addr != STATUS);
  assign clearAccess  = start && write && (addr == STATUS);

  // Preset lands on the edge where ack rises
  assign initialValue = presetAccess ? wdata.countView.count : '0;

  for (genvar k = 0; k < `PERF_NUM_COUNTERS; k++) begin : genCounter
    assign reinit[k] = presetAccess && (addr == regAddrT'(k));
    // Only saturating counters report sitting at the maximum
    assign saturatedNow[k] = saturateMask[k] && (value[k] == `PERF_MAX_VALUE);
  end

  // Read mux sees counter values before this edge's update
  always_comb begin
    readWord = '0;
    case (addr)
      COUNT0: readWord.countView.count = value[0];
      COUNT1: readWord.countView.count = value[1];
      COUNT2: readWord.countView.count = value[2];
      COUNT3: readWord.countView.count = value[3];
      STATUS: begin
        readWord.statusView.saturatedNow = saturatedNow;
        readWord.statusView.sticky       = sticky;
      end
      default: readWord = '0;
    endcase
  end

  // Handshake state
  // ack holds while req stays high so nothing repeats
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  // Read data captured with the access
  always_ff @(posedge clk) begin
    if (start) begin
      rdata <= readWord;
    end
  end

  // Sticky flags
  // A new overflow beats a clear in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      sticky <= '0;
    end else if (clearAccess) begin
      sticky <= (sticky & ~wdata.statusView.sticky) | overflow;
    end else begin
      sticky <= sticky | overflow;
    end
  end

  // Slave never releases ack ahead of the master
  ackFallA: assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> !$past(req))
    else $error("ack dropped while req was still high");

  // At most one counter preset at a time
  reinitOneHotA: assert property (@(posedge clk) disable iff (rst)
    $onehot0(reinit))
    else $error("preset not one hot");

  // A preset lasts a single cycle
  reinitPulseA: assert property (@(posedge clk) disable iff (rst)
    (reinit != '0) |=> (reinit == '0))
    else $error("preset longer than one cycle");

endmodule

//--- source/perfCounterUnit.sv
// ==========================================================
// Performance event counter unit, top level
// Four counters, three event lanes each
// Counters 0 and 1 wrap, counters 2 and 3 saturate
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module perfCounterUnit
  import perfEventPkg::*;
  import perfRegPkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [`PERF_NUM_COUNTERS*`PERF_NUM_LANES-1:0] events,
  input  logic                                         req,
  input  logic                                         write,
  input  regAddrT                                      addr,
  input  regWordT                                      wdata,
  output logic                                         ack,
  output regWordT                                      rdata
);

  localparam logic [`PERF_NUM_COUNTERS-1:0] saturateMask = `PERF_SATURATE_MASK;

  incrT                          incr [`PERF_NUM_COUNTERS];
  logic [`PERF_NUM_COUNTERS-1:0] incrValid;
  logic [`PERF_NUM_COUNTERS-1:0] reinit;
  countT                         initialValue;
  countT                         value [`PERF_NUM_COUNTERS];
  logic [`PERF_NUM_COUNTERS-1:0] overflow;

  // Lane registers and per counter increments
  eventLaneCount uLaneCount (
    .clk      (clk),
    .rst      (rst),
    .events   (events),
    .incr     (incr),
    .incrValid(incrValid)
  );

  for (genvar k = 0; k < `PERF_NUM_COUNTERS; k++) begin : genCounter
    counterIncr #(
      .enableSaturate(saturateMask[k])
    ) uCounter (
      .clk         (clk),
      .rst         (rst),
      .reinit      (reinit[k]),
      .initialValue(initialValue),
      .incrValid   (incrValid[k]),
      .incr        (incr[k]),
      .value       (value[k]),
      .valueNext   (),
      .overflow    (overflow[k])
    );
  end

  // Register port
  perfRegAccess uRegAccess (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .write       (write),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .value       (value),
    .overflow    (overflow),
    .reinit      (reinit),
    .initialValue(initialValue)
  );

endmodule

//--- bench/perfCounterUnitTb.sv
// ==========================================================
// Testbench for the performance counter unit
// Expected counts come from a model of the overflow rule
// Events are held low and drained before each access
// ==========================================================

`timescale 1ns/1ns

`include "perfCounter_defs.svh"

module perfCounterUnitTb
  import perfEventPkg::*;
  import perfRegPkg::*;
();

  // One table row: events for some cycles, then an optional access
  typedef struct packed {
    logic [11:0] pattern;
    bit          rnd;
    int          reps;
    bit          op;
    bit          wr;
    regAddrT     a;
    regWordT     wd;
    bit          fixedExp;
    regWordT     exp;
  } rowT;

  logic                                         clk;
  logic                                         rst;
  logic [`PERF_NUM_COUNTERS*`PERF_NUM_LANES-1:0] events;
  logic                                         req;
  logic                                         write;
  regAddrT                                      addr;
  regWordT                                      wdata;
  logic                                         ack;
  regWordT                                      rdata;

  rowT        rows [$];
  int         modelCount [`PERF_NUM_COUNTERS];
  logic [3:0] modelSticky;
  int         cycleCount = 0;
  int         cycleLimit = 0;

  perfCounterUnit i_dut (
    .clk   (clk),
    .rst   (rst),
    .events(events),
    .req   (req),
    .write (write),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      failRun("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkCount(input regWordT got, input countT exp);
    if (got.countView.count !== exp || got.countView.reserved !== '0) begin
      failRun($sformatf("Mismatch at %0t ns: count read %0d (word %h), expected %0d",
        $time, got.countView.count, got, exp));
    end
  endtask

  task automatic checkStatus(input regWordT got, input regWordT exp);
    if (got !== exp) begin
      failRun($sformatf("Mismatch at %0t ns: status read %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic protocolError(input string msg);
    failRun($sformatf("Handshake error at %0t ns: %s", $time, msg));
  endtask

  task automatic addRow(input logic [11:0] pattern, input bit rnd, input int reps,
                        input bit op, input bit wr, input regAddrT a, input regWordT wd,
                        input bit fixedExp, input regWordT exp);
    rowT row;
    row = '{pattern, rnd, reps, op, wr, a, wd, fixedExp, exp};
    rows.push_back(row);
  endtask

  function automatic int laneTotal(input laneVec lanes);
    int total;
    total = 0;
    for (int i = 0; i < `PERF_NUM_LANES; i++) begin
      total += lanes[i];
    end
    return total;
  endfunction

  // Model one cycle of events, counters 2 and 3 saturate
  task automatic applyEvents(input logic [11:0] pat);
    int total;
    for (int k = 0; k < `PERF_NUM_COUNTERS; k++) begin
      total = modelCount[k] + laneTotal(pat[k*3 +: 3]);
      if (total > `PERF_MAX_VALUE) begin
        modelSticky[k] = 1'b1;
        modelCount[k] = (k >= 2) ? `PERF_MAX_VALUE : total - `PERF_MAX_VALUE - 1;
      end else begin
        modelCount[k] = total;
      end
    end
  endtask

  function automatic regWordT expectedStatus();
    regWordT w;
    w = '0;
    w.statusView.sticky = modelSticky;
    for (int k = 2; k < `PERF_NUM_COUNTERS; k++) begin
      w.statusView.saturatedNow[k] = (modelCount[k] == `PERF_MAX_VALUE);
    end
    return w;
  endfunction

  // Four phase access with ack timing checks
  task automatic doAccess(input bit wr, input regAddrT a, input regWordT wd,
                          output regWordT got);
    @(posedge clk);
    events <= '0;
    @(posedge clk);
    req   <= 1'b1;
    write <= wr;
    addr  <= a;
    wdata <= wd;
    @(negedge clk);
    if (ack !== 1'b0) protocolError("ack was high before req was sampled");
    @(negedge clk);
    if (ack !== 1'b1) protocolError("ack did not rise one cycle after req");
    got = rdata;
    // Held req must not start a second access
    @(negedge clk);
    if (ack !== 1'b1 || rdata !== got) protocolError("ack or rdata moved while req was held");
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    if (ack !== 1'b1) protocolError("ack fell before req was sampled low");
    @(negedge clk);
    if (ack !== 1'b0) protocolError("ack did not fall one cycle after req dropped");
  endtask

  task automatic runRow(input rowT row);
    logic [11:0] pat;
    regWordT     got;
    for (int r = 0; r < row.reps; r++) begin
      pat = row.rnd ? 12'($urandom) : row.pattern;
      @(posedge clk);
      events <= pat;
      applyEvents(pat);
    end
    if (row.op) begin
      doAccess(row.wr, row.a, row.wd, got);
      if (row.wr && row.a == STATUS) begin
        modelSticky = modelSticky & ~row.wd.statusView.sticky;
      end else if (row.wr) begin
        modelCount[int'(row.a)] = row.wd.countView.count;
      end else if (row.a == STATUS) begin
        checkStatus(got, row.fixedExp ? row.exp : expectedStatus());
      end else begin
        checkCount(got, row.fixedExp ? row.exp.countView.count
                                     : countT'(modelCount[int'(row.a)]));
      end
    end
  endtask

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    events = '0;
    req    = 1'b0;
    write  = 1'b0;
    addr   = COUNT0;
    wdata  = '0;
    modelSticky = '0;
    for (int k = 0; k < `PERF_NUM_COUNTERS; k++) begin
      modelCount[k] = 0;
    end
    void'($urandom(32'h1bb8));

    // pattern, random, repeats, access, write, addr, wdata, fixed expect, expected rdata
    // Reset values
    addRow(12'h000, 0, 0, 1, 0, COUNT0, 16'h0000, 1, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT1, 16'h0000, 1, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT2, 16'h0000, 1, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT3, 16'h0000, 1, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 1, 16'h0000);
    // Lane counting, 0 to 3 lanes per counter
    addRow({3'b111, 3'b101, 3'b010, 3'b000}, 0, 5, 0, 0, COUNT0, 16'h0, 0, 16'h0);
    addRow({3'b000, 3'b001, 3'b110, 3'b111}, 0, 3, 0, 0, COUNT0, 16'h0, 0, 16'h0);
    addRow({3'b100, 3'b000, 3'b011, 3'b101}, 0, 4, 1, 0, COUNT0, 16'h0, 0, 16'h0);
    addRow(12'h000, 0, 0, 1, 0, COUNT1, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT2, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT3, 16'h0000, 0, 16'h0000);
    // Wrap of counter 0
    addRow(12'h000, 0, 0, 1, 1, COUNT0, 16'd999, 0, 16'h0000);
    addRow(12'h007, 0, 1, 1, 0, COUNT0, 16'h0000, 1, 16'd1);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 1, 16'h0001);
    // Saturation of counter 2, then partial sticky clears
    addRow(12'h000, 0, 0, 1, 1, COUNT2, 16'd998, 0, 16'h0000);
    addRow(12'h1c0, 0, 2, 1, 0, COUNT2, 16'h0000, 1, 16'd1000);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 1, 16'h0405);
    addRow(12'h000, 0, 0, 1, 1, STATUS, 16'h0004, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 1, 16'h0401);
    addRow(12'h000, 0, 0, 1, 1, STATUS, 16'h0001, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 1, 16'h0400);
    // Random stretch
    addRow(12'h000, 1, 200, 1, 0, COUNT0, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT1, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT2, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, COUNT3, 16'h0000, 0, 16'h0000);
    addRow(12'h000, 0, 0, 1, 0, STATUS, 16'h0000, 0, 16'h0000);

    // Repeats plus 6 cycles per access plus slack
    foreach (rows[i]) begin
      cycleLimit += rows[i].reps + (rows[i].op ? 6 : 0);
    end
    cycleLimit += 100;

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    foreach (rows[i]) begin
      runRow(rows[i]);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- perfCounterUnit.f
+incdir+source
source/perfEventPkg.sv
source/perfRegPkg.sv
source/eventLaneCount.sv
source/counterIncrMonitor.sv
source/counterIncr.sv
source/perfRegAccess.sv
source/perfCounterUnit.sv
bench/perfCounterUnitTb.sv

//--- Bender.yml
package:
  name: perfCounterUnit

sources:
  - include_dirs:
      - source
    files:
      - source/perfEventPkg.sv
      - source/perfRegPkg.sv
      - source/eventLaneCount.sv
      - source/counterIncrMonitor.sv
      - source/counterIncr.sv
      - source/perfRegAccess.sv
      - source/perfCounterUnit.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/perfCounterUnitTb.sv
